/* common/dma_fifo_pkg.sv */
/*
  Shared widths and strobe bundles for the SCSI DMA data FIFO.
  Modules refer to these by scoped names through dma_fifo_pkg::
*/
package dma_fifo_pkg;

  // Data path widths
  localparam int word_w    = 32;
  localparam int byte_w    = 8;
  localparam int num_lanes = word_w / byte_w;  // Four byte lanes
  localparam int count_w   = 4;                // Holds 0 to 8

  typedef logic [word_w-1:0]    fifo_word_t;   // Long word in and out
  typedef logic [byte_w-1:0]    fifo_byte_t;   // One lane value
  typedef logic [1:0]           byte_ptr_t;    // 0 = most significant byte
  typedef logic [num_lanes-1:0] lane_we_t;     // Bit 3 is the top lane
  typedef logic [count_w-1:0]   fifo_count_t;  // Occupancy

  // Write side strobes from the CPU and SCSI state machines
  typedef struct packed {
    logic ld_lower_word;  // CPU loads lanes 1 and 0
    logic ld_upper_word;  // CPU loads lanes 3 and 2
    logic ld_byte;        // SCSI loads the lane under the byte pointer
    logic inc_byte_ptr;   // Step to the next byte
    logic inc_next_in;    // Advance the write entry
  } fifo_wr_req_t;

  // Write to the $0C control register
  typedef struct packed {
    logic acr_wr;   // Register write strobe
    logic addr_0c;  // Address decode hit
    logic mid25;    // Start on the upper half
  } fifo_acr_wr_t;

  // Read side strobes
  typedef struct packed {
    logic inc_fifo;      // One more entry held
    logic dec_fifo;      // One entry taken
    logic inc_next_out;  // Advance the read entry
  } fifo_rd_req_t;

endpackage

/* source/fifo_write_port.sv */
/*
  Write side of the DMA FIFO. Keeps the SCSI byte pointer and the
  next-in entry, and turns word and byte strobes into lane enables.
*/
`timescale 1ns/1ns

module fifo_write_port #(
  parameter int ptr_w = 3
) (
  input  logic                        LLWS,
  input  logic                        rst_n,
  input  logic                        rst_fifo_n,
  input  dma_fifo_pkg::fifo_wr_req_t  wr_req,
  input  dma_fifo_pkg::fifo_acr_wr_t  acr,
  output dma_fifo_pkg::lane_we_t      lane_we,
  output logic [ptr_w-1:0]            wr_ptr,
  output dma_fifo_pkg::byte_ptr_t     byte_ptr,
  output logic                        bo_eq0,   // First byte
  output logic                        bo_eq3    // Last byte
);

  logic clr;         // Either reset clears the pointers
  logic acr_preset;  // $0C write loads the byte pointer

  assign clr        = !rst_n || !rst_fifo_n;
  assign acr_preset = acr.acr_wr && acr.addr_0c;

  // Byte pointer
  // A preset wins over an increment in the same cycle
  always_ff @(posedge LLWS) begin
    if (clr) begin
      byte_ptr <= '0;
    end else if (acr_preset) begin
      byte_ptr <= acr.mid25 ? 2'd2 : 2'd0;  // Upper half starts at byte 2
    end else if (wr_req.inc_byte_ptr) begin
      byte_ptr <= byte_ptr + 2'd1;          // Wraps 3 to 0
    end
  end

  assign bo_eq0 = (byte_ptr == 2'd0);
  assign bo_eq3 = (byte_ptr == 2'd3);

  // Next-in entry, modulo depth
  always_ff @(posedge LLWS) begin
    if (clr) begin
      wr_ptr <= '0;
    end else if (wr_req.inc_next_in) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Lane enables in big-endian order
  always_comb begin
    lane_we = '0;
    if (wr_req.ld_lower_word) begin
      lane_we[1:0] = 2'b11;
    end
    if (wr_req.ld_upper_word) begin
      lane_we[3:2] = 2'b11;
    end
    if (wr_req.ld_byte) begin
      lane_we[2'd3 - byte_ptr] = 1'b1;  // Pointer 0 hits lane 3
    end
  end

  // SCSI byte loads and CPU word loads never overlap
  a_byte_vs_word : assert property (
    @(posedge LLWS) disable iff (!rst_n)
    wr_req.ld_byte |-> !(wr_req.ld_lower_word || wr_req.ld_upper_word)
  ) else $error("ld_byte together with a word load");

endmodule

/* source/fifo_byte_lane.sv */
/*
  One 8-bit lane of the FIFO storage. Written at wr_ptr on LLWS when
  enabled, read combinationally at rd_ptr. Four lanes form the buffer.
*/
`timescale 1ns/1ns

module fifo_byte_lane #(
  parameter int ptr_w = 3
) (
  input  logic                      LLWS,
  input  logic                      we,      // Lane write enable
  input  logic [ptr_w-1:0]          wr_ptr,  // Next in
  input  logic [ptr_w-1:0]          rd_ptr,  // Next out
  input  dma_fifo_pkg::fifo_byte_t  d,
  output dma_fifo_pkg::fifo_byte_t  q
);

  localparam int depth = 1 << ptr_w;

  dma_fifo_pkg::fifo_byte_t mem [depth];  // Contents not cleared

  // Only this lane's byte changes on a write
  always_ff @(posedge LLWS) begin
    if (we) begin
      mem[wr_ptr] <= d;
    end
  end

  assign q = mem[rd_ptr];  // Async read, no output register

endmodule

/* source/fifo_read_port.sv */
/*
  Read side of the DMA FIFO. Next-out entry, occupancy count with
  registered full and empty flags, and the output word from the lanes.
*/
`timescale 1ns/1ns

module fifo_read_port #(
  parameter int ptr_w = 3
) (
  input  logic                                              LLWS,
  input  logic                                              rst_n,
  input  logic                                              rst_fifo_n,
  input  dma_fifo_pkg::fifo_rd_req_t                        rd_req,
  input  dma_fifo_pkg::fifo_byte_t [dma_fifo_pkg::num_lanes-1:0] lane_q,
  output logic [ptr_w-1:0]                                  rd_ptr,
  output dma_fifo_pkg::fifo_word_t                          od,
  output logic                                              fifo_full,
  output logic                                              fifo_empty
);

  localparam dma_fifo_pkg::fifo_count_t depth = dma_fifo_pkg::fifo_count_t'(1 << ptr_w);

  logic                      clr;
  dma_fifo_pkg::fifo_count_t count;      // Entries held
  dma_fifo_pkg::fifo_count_t count_nxt;

  assign clr = !rst_n || !rst_fifo_n;

  // Next-out entry, modulo depth
  always_ff @(posedge LLWS) begin
    if (clr) begin
      rd_ptr <= '0;
    end else if (rd_req.inc_next_out) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Up and down together cancel out
  always_comb begin
    case ({rd_req.inc_fifo, rd_req.dec_fifo})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  // Flags follow the next count so they line up with count
  always_ff @(posedge LLWS) begin
    if (clr) begin
      count      <= '0;
      fifo_full  <= 1'b0;
      fifo_empty <= 1'b1;
    end else begin
      count      <= count_nxt;
      fifo_full  <= (count_nxt == depth);
      fifo_empty <= (count_nxt == '0);
    end
  end

  // Lane 3 is the most significant byte
  assign od = {lane_q[3], lane_q[2], lane_q[1], lane_q[0]};

  // No back-pressure in hardware, so the FSMs must respect the flags
  a_no_overflow : assert property (
    @(posedge LLWS) disable iff (clr)
    (rd_req.inc_fifo && !rd_req.dec_fifo) |-> !fifo_full
  ) else $error("inc_fifo while full");

  a_no_underflow : assert property (
    @(posedge LLWS) disable iff (clr)
    (rd_req.dec_fifo && !rd_req.inc_fifo) |-> !fifo_empty
  ) else $error("dec_fifo while empty");

endmodule

/* source/dma_fifo.sv */
/*
  Top level of the 32-byte DMA data FIFO. Write port, four byte lanes
  and read port, all on LLWS. Strobes come straight from the bus FSMs.
*/
`timescale 1ns/1ns

module dma_fifo #(
  parameter int ptr_w = 3  // Eight entries by default
) (
  input  logic                        LLWS,
  input  logic                        rst_n,
  input  logic                        rst_fifo_n,  // FIFO only clear
  input  dma_fifo_pkg::fifo_wr_req_t  wr_req,
  input  dma_fifo_pkg::fifo_acr_wr_t  acr,
  input  dma_fifo_pkg::fifo_rd_req_t  rd_req,
  input  dma_fifo_pkg::fifo_word_t    id,
  output dma_fifo_pkg::fifo_word_t    od,
  output logic                        fifo_full,
  output logic                        fifo_empty,
  output dma_fifo_pkg::byte_ptr_t     byte_ptr,
  output logic                        bo_eq0,
  output logic                        bo_eq3
);

  dma_fifo_pkg::lane_we_t                               lane_we;  // Per lane enables
  logic [ptr_w-1:0]                                     wr_ptr;   // Next in
  logic [ptr_w-1:0]                                     rd_ptr;   // Next out
  dma_fifo_pkg::fifo_byte_t [dma_fifo_pkg::num_lanes-1:0] lane_q;

  // Byte pointer, next-in counter and lane decode
  fifo_write_port #(
    .ptr_w (ptr_w)
  ) u_write_port (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .wr_req     (wr_req),
    .acr        (acr),
    .lane_we    (lane_we),
    .wr_ptr     (wr_ptr),
    .byte_ptr   (byte_ptr),
    .bo_eq0     (bo_eq0),
    .bo_eq3     (bo_eq3)
  );

  // Lane i stores byte i of id
  for (genvar i = 0; i < dma_fifo_pkg::num_lanes; i++) begin : g_lane
    fifo_byte_lane #(
      .ptr_w (ptr_w)
    ) u_lane (
      .LLWS   (LLWS),
      .we     (lane_we[i]),
      .wr_ptr (wr_ptr),
      .rd_ptr (rd_ptr),
      .d      (id[dma_fifo_pkg::byte_w*i +: dma_fifo_pkg::byte_w]),
      .q      (lane_q[i])
    );
  end

  // Next-out counter, occupancy and output word
  fifo_read_port #(
    .ptr_w (ptr_w)
  ) u_read_port (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .rd_req     (rd_req),
    .lane_q     (lane_q),
    .rd_ptr     (rd_ptr),
    .od         (od),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

endmodule

/* verif/dma_fifo_tb.sv */
/*
  Testbench for the DMA data FIFO. Directed steps from a table, then
  random mixed traffic, each checked one cycle later against a model.
*/
`timescale 1ns/1ns

module dma_fifo_tb;

  localparam int ptr_w     = 3;
  localparam int depth     = 1 << ptr_w;
  localparam int timeout   = 20;             // Cycles allowed for a flag wait
  localparam int n_rand    = 60;             // Random steps after the table
  localparam logic [31:0] lfsr_taps = 32'h80200003;

  // Strobe bits in struct field order
  localparam logic [4:0] w_lower   = 5'b10000;
  localparam logic [4:0] w_upper   = 5'b01000;
  localparam logic [4:0] w_byte    = 5'b00100;
  localparam logic [4:0] w_bptr    = 5'b00010;
  localparam logic [4:0] w_next_in = 5'b00001;
  localparam logic [2:0] a_wr      = 3'b100;
  localparam logic [2:0] a_0c      = 3'b010;
  localparam logic [2:0] a_mid25   = 3'b001;
  localparam logic [2:0] r_inc     = 3'b100;
  localparam logic [2:0] r_dec     = 3'b010;
  localparam logic [2:0] r_out     = 3'b001;
  localparam logic [2:0] chk_all   = 3'b111;  // od, full/empty, byte pointer
  localparam logic [2:0] chk_ctl   = 3'b011;

  typedef struct packed {
    dma_fifo_pkg::fifo_wr_req_t wr;
    dma_fifo_pkg::fifo_acr_wr_t acr;
    dma_fifo_pkg::fifo_rd_req_t rd;
    logic                       clr;  // Pulse rst_fifo_n low
    logic [2:0]                 chk;
  } step_t;

  logic                       LLWS;
  logic                       rst_n;
  logic                       rst_fifo_n;
  dma_fifo_pkg::fifo_wr_req_t wr_req;
  dma_fifo_pkg::fifo_acr_wr_t acr;
  dma_fifo_pkg::fifo_rd_req_t rd_req;
  dma_fifo_pkg::fifo_word_t   id;
  dma_fifo_pkg::fifo_word_t   od;
  logic                       fifo_full;
  logic                       fifo_empty;
  dma_fifo_pkg::byte_ptr_t    byte_ptr;
  logic                       bo_eq0;
  logic                       bo_eq3;

  // Reference model
  dma_fifo_pkg::fifo_word_t mem_m [depth];
  logic [3:0]               valid_m [depth];  // Lanes written at least once
  logic [ptr_w-1:0]         wp_m;
  logic [ptr_w-1:0]         rp_m;
  int                       cnt_m;
  dma_fifo_pkg::byte_ptr_t  bp_m;

  string       step_name [$];
  step_t       step_q [$];
  logic [31:0] lfsr;
  int          errors;
  int          tests;
  int          failed;
  logic        test_ok;

  initial LLWS = 1'b0;
  always #50 LLWS = ~LLWS;  // 100 ns period

  dma_fifo #(
    .ptr_w (ptr_w)
  ) i_dma_fifo (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .wr_req     (wr_req),
    .acr        (acr),
    .rd_req     (rd_req),
    .id         (id),
    .od         (od),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .byte_ptr   (byte_ptr),
    .bo_eq0     (bo_eq0),
    .bo_eq3     (bo_eq3)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic dma_fifo_pkg::fifo_word_t lane_mask(input logic [3:0] v);
    dma_fifo_pkg::fifo_word_t m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{v[i]}};
    end
    return m;
  endfunction

  task automatic add_step(input string name, input logic [4:0] wr_v, input logic [2:0] acr_v,
                          input logic [2:0] rd_v, input logic clr, input logic [2:0] chk);
    step_t s;
    s.wr  = wr_v;
    s.acr = acr_v;
    s.rd  = rd_v;
    s.clr = clr;
    s.chk = chk;
    step_name.push_back(name);
    step_q.push_back(s);
  endtask

  task automatic check_word(input string name, input dma_fifo_pkg::fifo_word_t exp,
                            input dma_fifo_pkg::fifo_word_t act);
    if (act !== exp) begin
      $display("Error %s: od expected %h, actual %h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_byte_ptr(input string name, input dma_fifo_pkg::byte_ptr_t exp,
                                input dma_fifo_pkg::byte_ptr_t act);
    if (act !== exp) begin
      $display("Error %s: byte_ptr expected %0d, actual %0d", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_flag(input string name, input string flag, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("Error %s: %s expected %b, actual %b", name, flag, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  // Bounded wait on full (want_full) or empty
  task automatic wait_flag(input string name, input logic want_full);
    int n;
    n = 0;
    while ((want_full ? fifo_full : fifo_empty) !== 1'b1 && n < timeout) begin
      @(negedge LLWS);
      n++;
    end
    if ((want_full ? fifo_full : fifo_empty) !== 1'b1) begin
      $display("%s: %s did not rise within %0d cycles", name,
               want_full ? "fifo_full" : "fifo_empty", timeout);
      errors++;
    end
  endtask

  // Model update for the edge that samples step s
  task automatic model_step(input step_t s, input dma_fifo_pkg::fifo_word_t d);
    logic hit;
    for (int i = 0; i < 4; i++) begin
      hit = (i < 2) ? s.wr.ld_lower_word : s.wr.ld_upper_word;
      hit = hit || (s.wr.ld_byte && int'(bp_m) == 3 - i);  // Pointer 0 is lane 3
      if (hit) begin
        mem_m[wp_m][8*i +: 8] = d[8*i +: 8];
        valid_m[wp_m][i]      = 1'b1;
      end
    end
    if (s.clr) begin
      wp_m  = '0;
      rp_m  = '0;
      cnt_m = 0;
      bp_m  = '0;
    end else begin
      if (s.acr.acr_wr && s.acr.addr_0c) bp_m = s.acr.mid25 ? 2'd2 : 2'd0;
      else if (s.wr.inc_byte_ptr) bp_m = bp_m + 2'd1;
      if (s.wr.inc_next_in) wp_m = wp_m + 1'b1;
      if (s.rd.inc_next_out) rp_m = rp_m + 1'b1;
      if (s.rd.inc_fifo && !s.rd.dec_fifo) cnt_m++;
      else if (s.rd.dec_fifo && !s.rd.inc_fifo) cnt_m--;
    end
  endtask

  task automatic apply_step(input string name, input step_t s);
    dma_fifo_pkg::fifo_word_t d;
    dma_fifo_pkg::fifo_word_t m;
    d       = lfsr_bits(32);
    test_ok = 1'b1;
    @(posedge LLWS);
    wr_req     <= s.wr;
    acr        <= s.acr;
    rd_req     <= s.rd;
    id         <= d;
    rst_fifo_n <= !s.clr;
    @(posedge LLWS);  // DUT samples the step here
    wr_req     <= '0;
    acr        <= '0;
    rd_req     <= '0;
    rst_fifo_n <= 1'b1;
    model_step(s, d);
    @(negedge LLWS);
    m = lane_mask(valid_m[rp_m]);  // Unwritten lanes hold no known value
    if (s.chk[2]) check_word(name, mem_m[rp_m] & m, od & m);
    if (s.chk[1]) begin
      check_flag(name, "fifo_full", cnt_m == depth, fifo_full);
      check_flag(name, "fifo_empty", cnt_m == 0, fifo_empty);
    end
    if (s.chk[0]) begin
      check_byte_ptr(name, bp_m, byte_ptr);
      check_flag(name, "bo_eq0", bp_m == 2'd0, bo_eq0);
      check_flag(name, "bo_eq3", bp_m == 2'd3, bo_eq3);
    end
    $display("%s %s", test_ok ? "ok  " : "FAIL", name);
    tests++;
    if (!test_ok) failed++;
  endtask

  // Legal random step chosen from the model state
  function automatic step_t rand_step();
    step_t       s;
    logic [31:0] r;
    r     = lfsr_bits(3);
    s     = '0;
    s.chk = chk_all;
    if (cnt_m == depth) r[1:0] = 2'd3;                  // Full, so read
    else if (cnt_m == 0 && r[1:0] == 2'd3) r[1:0] = 2'd1;
    case (r[1:0])
      2'd0: s.wr = w_upper;
      2'd1: begin
        s.wr = w_lower | w_next_in;
        s.rd = (r[2] && cnt_m != 0) ? (r_inc | r_dec | r_out) : r_inc;  // Write and read
      end
      2'd2: begin
        s.wr = w_byte | w_bptr;
        if (bp_m == 2'd3) begin
          s.wr = w_byte | w_bptr | w_next_in;  // Last byte closes the entry
          s.rd = r_inc;
        end
      end
      default: s.rd = r_dec | r_out;
    endcase
    return s;
  endfunction

  task automatic build_table();
    add_step("reset_state", '0, '0, '0, 1'b0, chk_ctl);
    for (int e = 0; e < depth; e++) begin
      add_step($sformatf("word_fill_%0d_upper", e), w_upper, '0, '0, 1'b0, chk_all);
      add_step($sformatf("word_fill_%0d_lower", e), w_lower | w_next_in, '0, r_inc, 1'b0,
               chk_all);
    end
    for (int e = 0; e < depth; e++) begin
      add_step($sformatf("word_drain_%0d", e), '0, '0, r_out | r_dec, 1'b0, chk_all);
    end
    for (int b = 0; b < 4; b++) begin
      add_step($sformatf("byte_load_%0d", b), w_byte | w_bptr, '0, '0, 1'b0, chk_all);
    end
    add_step("byte_commit", w_next_in, '0, r_inc, 1'b0, chk_all);
    add_step("byte_drain", '0, '0, r_out | r_dec, 1'b0, chk_all);
    add_step("acr_mid25", '0, a_wr | a_0c | a_mid25, '0, 1'b0, chk_all);
    add_step("acr_lane1_only", w_byte, '0, '0, 1'b0, chk_all);
    add_step("acr_start0", '0, a_wr | a_0c, '0, 1'b0, chk_all);
    add_step("acr_step", w_bptr, '0, '0, 1'b0, chk_all);
    add_step("acr_miss", '0, a_wr | a_mid25, '0, 1'b0, chk_all);     // No address hit
    add_step("acr_over_inc", w_bptr, a_wr | a_0c, '0, 1'b0, chk_all);  // Preset to 0, not 2
    add_step("pre_clear_word", w_upper | w_lower | w_next_in | w_bptr, '0, r_inc, 1'b0,
             chk_all);
    add_step("fifo_clear", '0, '0, '0, 1'b1, chk_all);
  endtask

  initial begin
    lfsr       = 32'd98805;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    rst_n      = 1'b0;
    rst_fifo_n = 1'b1;
    wr_req     = '0;
    acr        = '0;
    rd_req     = '0;
    id         = '0;
    wp_m       = '0;
    rp_m       = '0;
    cnt_m      = 0;
    bp_m       = '0;
    for (int e = 0; e < depth; e++) begin
      mem_m[e]   = '0;
      valid_m[e] = '0;
    end
    build_table();
    repeat (2) @(posedge LLWS);
    rst_n <= 1'b1;
    wait_flag("reset", 1'b0);
    foreach (step_q[k]) apply_step(step_name[k], step_q[k]);
    wait_flag("after_clear", 1'b0);
    for (int k = 0; k < n_rand; k++) begin
      apply_step($sformatf("random_%0d", k), rand_step());
    end
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* src.f */
common/dma_fifo_pkg.sv
source/fifo_write_port.sv
source/fifo_byte_lane.sv
source/fifo_read_port.sv
source/dma_fifo.sv
verif/dma_fifo_tb.sv

/* Makefile */
# Verilator build for the DMA data FIFO

VERILATOR  ?= verilator
TOP        = dma_fifo_tb
RTL_TOP    = dma_fifo
FILELIST   = src.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
